// ==== include/task_array_macros.svh ====
`ifndef TASK_ARRAY_MACROS_SVH
`define TASK_ARRAY_MACROS_SVH

// Array geometry
`define TA_NUM_CORES      4
`define TA_TM_DEPTH       16

// An instruction reaches the cores in this many parts
`define TA_INSN_LOAD_TIME 2
`define TA_PART_W         16

// Data widths
`define TA_R0_W           16
`define TA_TM_W           96

// Display pacing, in clk cycles
`define TA_BIG_TACT       64 // Divider period
`define TA_SCAN_CYCLES    32 // One display frame

// Core opcodes
`define TA_OP_ADD         4'd0
`define TA_OP_SUB         4'd1
`define TA_OP_XOR         4'd2
`define TA_OP_SHL         4'd3

`endif

// ==== task_array_top.f ====
+incdir+include
verilog/task_array_pkg.sv
verilog/task_memory.sv
verilog/task_scheduler.sv
verilog/array_core.sv
verilog/display_sync.sv
verilog/task_array_top.sv
tb/task_array_tb.sv

// ==== tb/task_array_tb.sv ====
`timescale 1ns/100ps
`include "task_array_macros.svh"

module task_array_tb;

	localparam int NUM_TESTS     = 6;
	localparam int MAX_FRAMES    = 3;
	localparam int FRAME_TIMEOUT = 2000; // Cycles allowed per frame

	logic                                    clk;
	logic                                    reset;
	logic                                    tm_we;
	task_array_pkg::tm_addr_t                tm_addr;
	task_array_pkg::tm_word_t                tm_wdata;
	logic                                    frame_done;
	task_array_pkg::r0_t [`TA_NUM_CORES-1:0] r0_snapshot;

	// Program table with one row per test
	task_array_pkg::tm_word_t prog_image [NUM_TESTS][`TA_TM_DEPTH];
	int                       frame_count [NUM_TESTS];
	task_array_pkg::r0_t      exp_snap [NUM_TESTS][MAX_FRAMES][`TA_NUM_CORES];

	int error_count;
	int check_count;

	task_array_top dut_i (
		.clk         (clk),
		.reset       (reset),
		.tm_we       (tm_we),
		.tm_addr     (tm_addr),
		.tm_wdata    (tm_wdata),
		.frame_done  (frame_done),
		.r0_snapshot (r0_snapshot)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic task_array_pkg::tm_word_t ctrl_word(
		input task_array_pkg::frame_cnt_t cnt,
		input task_array_pkg::core_mask_t mask,
		input task_array_pkg::core_mask_t init,
		input task_array_pkg::fence_e     fence,
		input logic                       stop,
		input task_array_pkg::tm_addr_t   stop_addr,
		input task_array_pkg::r0_t        v0,
		input task_array_pkg::r0_t        v1,
		input task_array_pkg::r0_t        v2,
		input task_array_pkg::r0_t        v3
	);
		task_array_pkg::ctrl_frame_t c;
		c             = '0;
		c.frame_cnt   = cnt;
		c.core_mask   = mask;
		c.init_mask   = init;
		c.fence       = fence;
		c.stop        = stop;
		c.stop_addr   = stop_addr;
		c.init_val[0] = v0;
		c.init_val[1] = v1;
		c.init_val[2] = v2;
		c.init_val[3] = v3;
		return task_array_pkg::tm_word_t'(c);
	endfunction

	function automatic task_array_pkg::tm_word_t insn_word(input logic [3:0] op,
		input logic [3:0] exec_cycles, input logic [15:0] imm);
		task_array_pkg::insn_t    i;
		task_array_pkg::tm_word_t w;
		i             = '0;
		i.opcode      = op;
		i.exec_cycles = exec_cycles;
		i.imm         = imm;
		w             = '0;
		w[31:0]       = i; // Instruction sits in the low bits
		return w;
	endfunction

	// Expected effect of each core opcode
	function automatic task_array_pkg::r0_t apply_op(input task_array_pkg::r0_t val,
		input task_array_pkg::insn_t ins);
		case (ins.opcode)
			`TA_OP_ADD: return val + ins.imm;
			`TA_OP_SUB: return val - ins.imm;
			`TA_OP_XOR: return val ^ ins.imm;
			`TA_OP_SHL: return val << (ins.imm % 16);
			default:    return val;
		endcase
	endfunction

	task build_table();
		int t;
		int a;
		for (t = 0; t < NUM_TESTS; t++) begin
			for (a = 0; a < `TA_TM_DEPTH; a++) begin
				prog_image[t][a] = '0; // Zero word is a skip frame
			end
		end
		// Single add on core 0 with a stop back to 0
		prog_image[0][0] = ctrl_word(4'd1, 4'b0001, 4'b0001, task_array_pkg::fence_none,
			1'b1, 4'd0, 16'h0010, 16'h0, 16'h0, 16'h0);
		prog_image[0][1] = insn_word(`TA_OP_ADD, 4'd2, 16'h0005);
		frame_count[0]   = 2;
		// Cores 0 and 3 set first and then three ops on cores 1 and 2
		prog_image[1][0] = ctrl_word(4'd1, 4'b1001, 4'b1001, task_array_pkg::fence_none,
			1'b0, 4'd0, 16'h0aaa, 16'h0, 16'h0, 16'h0bbb);
		prog_image[1][1] = insn_word(`TA_OP_ADD, 4'd0, 16'h0001);
		prog_image[1][2] = ctrl_word(4'd3, 4'b0110, 4'b0110, task_array_pkg::fence_none,
			1'b1, 4'd0, 16'h0, 16'h1234, 16'h00ff, 16'h0);
		prog_image[1][3] = insn_word(`TA_OP_SUB, 4'd1, 16'h0011);
		prog_image[1][4] = insn_word(`TA_OP_XOR, 4'd3, 16'h0f0f);
		prog_image[1][5] = insn_word(`TA_OP_SHL, 4'd0, 16'h0003);
		frame_count[1]   = 1;
		// Two long disjoint tasks and then an acquire task over both cores
		prog_image[2][0] = ctrl_word(4'd1, 4'b0001, 4'b0001, task_array_pkg::fence_none,
			1'b0, 4'd0, 16'h0100, 16'h0, 16'h0, 16'h0);
		prog_image[2][1] = insn_word(`TA_OP_ADD, 4'd15, 16'h0001);
		prog_image[2][2] = ctrl_word(4'd1, 4'b0010, 4'b0010, task_array_pkg::fence_none,
			1'b0, 4'd0, 16'h0, 16'h0200, 16'h0, 16'h0);
		prog_image[2][3] = insn_word(`TA_OP_SUB, 4'd15, 16'h0002);
		prog_image[2][4] = ctrl_word(4'd2, 4'b0011, 4'b0000, task_array_pkg::fence_acq,
			1'b1, 4'd0, 16'h0, 16'h0, 16'h0, 16'h0);
		prog_image[2][5] = insn_word(`TA_OP_SHL, 4'd1, 16'h0001);
		prog_image[2][6] = insn_word(`TA_OP_XOR, 4'd0, 16'h00ff);
		frame_count[2]   = 1;
		// Release task on core 3 behind a busy core 2
		prog_image[3][0] = ctrl_word(4'd1, 4'b0100, 4'b0100, task_array_pkg::fence_none,
			1'b0, 4'd0, 16'h0, 16'h0, 16'h0300, 16'h0);
		prog_image[3][1] = insn_word(`TA_OP_ADD, 4'd12, 16'h0007);
		prog_image[3][2] = ctrl_word(4'd1, 4'b1000, 4'b1000, task_array_pkg::fence_rel,
			1'b1, 4'd0, 16'h0, 16'h0, 16'h0, 16'h0400);
		prog_image[3][3] = insn_word(`TA_OP_XOR, 4'd2, 16'h0055);
		frame_count[3]   = 1;
		// Stop address skips the init task so values accumulate
		prog_image[4][0] = ctrl_word(4'd1, 4'b1111, 4'b1111, task_array_pkg::fence_none,
			1'b0, 4'd0, 16'h0001, 16'h0002, 16'h0003, 16'h0004);
		prog_image[4][1] = insn_word(`TA_OP_ADD, 4'd1, 16'h0010);
		prog_image[4][2] = ctrl_word(4'd2, 4'b0101, 4'b0000, task_array_pkg::fence_none,
			1'b1, 4'd2, 16'h0, 16'h0, 16'h0, 16'h0);
		prog_image[4][3] = insn_word(`TA_OP_ADD, 4'd3, 16'h0003);
		prog_image[4][4] = insn_word(`TA_OP_XOR, 4'd0, 16'h0101);
		frame_count[4]   = 3;
		// Random ops and immediates on all cores
		prog_image[5][0] = ctrl_word(4'd2, 4'b1111, 4'b1111, task_array_pkg::fence_none,
			1'b0, 4'd0, 16'($urandom), 16'($urandom), 16'($urandom), 16'($urandom));
		prog_image[5][3] = ctrl_word(4'd2, 4'b1111, 4'b0000, task_array_pkg::fence_none,
			1'b1, 4'd3, 16'h0, 16'h0, 16'h0, 16'h0);
		for (a = 1; a < 6; a++) begin
			if (a != 3) begin
				prog_image[5][a] = insn_word(4'($urandom % 4), 4'($urandom % 8),
					16'($urandom));
			end
		end
		frame_count[5] = 2;
	endtask

	// Walks the frames of one row and records R0 at each stop
	task compute_expected(input int t);
		task_array_pkg::r0_t         model_r0 [`TA_NUM_CORES];
		task_array_pkg::ctrl_frame_t c;
		task_array_pkg::insn_t       ins;
		task_array_pkg::tm_addr_t    ptr;
		task_array_pkg::tm_addr_t    iaddr;
		int                          f;
		int                          i;
		int                          k;
		int                          steps;
		logic                        frame_end;
		for (i = 0; i < `TA_NUM_CORES; i++) begin
			model_r0[i] = '0;
		end
		ptr = '0;
		for (f = 0; f < frame_count[t]; f++) begin
			frame_end = 1'b0;
			steps     = 0;
			while (!frame_end && steps < 64) begin
				steps++;
				c = task_array_pkg::ctrl_frame_t'(prog_image[t][ptr]);
				if (c.frame_cnt == '0) begin
					ptr = c.stop ? c.stop_addr : ptr + 1'b1; // Jump or skip
				end else begin
					for (i = 0; i < `TA_NUM_CORES; i++) begin
						if (c.init_mask[i] && c.core_mask[i]) begin
							model_r0[i] = c.init_val[i];
						end
					end
					for (k = 1; k <= int'(c.frame_cnt); k++) begin
						iaddr = ptr + task_array_pkg::tm_addr_t'(k);
						ins   = task_array_pkg::insn_t'(prog_image[t][iaddr][31:0]);
						for (i = 0; i < `TA_NUM_CORES; i++) begin
							if (c.core_mask[i]) begin
								model_r0[i] = apply_op(model_r0[i], ins);
							end
						end
					end
					ptr = ptr + task_array_pkg::tm_addr_t'(c.frame_cnt) + 1'b1;
					if (c.stop) begin
						ptr       = c.stop_addr;
						frame_end = 1'b1; // Display frame happens here
					end
				end
			end
			for (i = 0; i < `TA_NUM_CORES; i++) begin
				exp_snap[t][f][i] = model_r0[i];
			end
		end
	endtask

	task load_program(input int t);
		int a;
		@(negedge clk);
		reset = 1'b1;
		repeat (4) @(negedge clk);
		for (a = 0; a < `TA_TM_DEPTH; a++) begin
			tm_we    = 1'b1;
			tm_addr  = task_array_pkg::tm_addr_t'(a);
			tm_wdata = prog_image[t][a];
			@(negedge clk);
		end
		tm_we = 1'b0;
		reset = 1'b0;
	endtask

	task wait_for_frame(output logic seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < FRAME_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (frame_done) begin
				seen = 1'b1;
			end
		end
	endtask

	initial begin
		int   t;
		int   f;
		int   i;
		int   errors_before;
		logic seen;
		reset       = 1'b1;
		tm_we       = 1'b0;
		tm_addr     = '0;
		tm_wdata    = '0;
		error_count = 0;
		check_count = 0;
		void'($urandom(32'h80a0));
		build_table();
		for (t = 0; t < NUM_TESTS; t++) begin
			compute_expected(t);
		end
		for (t = 0; t < NUM_TESTS; t++) begin
			errors_before = error_count;
			load_program(t);
			for (f = 0; f < frame_count[t]; f++) begin
				wait_for_frame(seen);
				if (!seen) begin
					$display("Test %0d timed out waiting for frame_done of frame %0d",
						t + 1, f + 1);
					error_count++;
					break;
				end
				for (i = 0; i < `TA_NUM_CORES; i++) begin
					check_count++;
					if (r0_snapshot[i] !== exp_snap[t][f][i]) begin
						$display("FAILED at %0t: r0_snapshot[%0d] frame %0d expected %h got %h",
							$time, i, f + 1, exp_snap[t][f][i], r0_snapshot[i]);
						error_count++;
					end
				end
			end
			$display("test %0d finished with %0d errors", t + 1, error_count - errors_before);
		end
		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, check_count, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== verilog/array_core.sv ====
`timescale 1ns/100ps
`include "task_array_macros.svh"

module array_core (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  task_array_pkg::core_bus_t core_bus,
	input  logic                      init_r0_en,
	input  task_array_pkg::r0_t       init_r0,
	output logic                      ready,
	output task_array_pkg::r0_t       r0
);

	task_array_pkg::core_state_e state;
	task_array_pkg::insn_t       insn;     // Assembled from bus parts
	task_array_pkg::r0_t         result;
	logic [3:0]                  exec_cnt;
	logic                        bus_last; // Part on the bus completes the instruction
	logic                        exec_done;

	assign bus_last  = (core_bus.count == task_array_pkg::load_cnt_t'(`TA_INSN_LOAD_TIME - 1));
	assign exec_done = (state == task_array_pkg::core_exec) && (exec_cnt == insn.exec_cycles);
	assign ready     = (state == task_array_pkg::core_idle);

	always_comb begin
		case (insn.opcode)
			`TA_OP_ADD: result = r0 + insn.imm;
			`TA_OP_SUB: result = r0 - insn.imm;
			`TA_OP_XOR: result = r0 ^ insn.imm;
			`TA_OP_SHL: result = r0 << insn.imm[3:0]; // Only low bits give the shift
			default:    result = r0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (start) begin
			insn[core_bus.count * `TA_PART_W +: `TA_PART_W] <= core_bus.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= task_array_pkg::core_idle;
			exec_cnt <= '0;
		end else begin
			case (state)
				task_array_pkg::core_idle: begin
					exec_cnt <= '0;
					if (start) begin
						state <= task_array_pkg::core_load;
					end
				end
				task_array_pkg::core_load: begin
					if (start && bus_last) begin
						state <= task_array_pkg::core_exec;
					end
				end
				task_array_pkg::core_exec: begin
					exec_cnt <= exec_cnt + 1'b1; // Runs exec_cycles+1 cycles
					if (exec_done) begin
						state <= task_array_pkg::core_idle;
					end
				end
				default: state <= task_array_pkg::core_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r0 <= '0;
		end else if (init_r0_en) begin
			r0 <= init_r0;
		end else if (exec_done) begin
			r0 <= result; // Written on the last exec cycle
		end
	end

endmodule

// ==== verilog/display_sync.sv ====
`timescale 1ns/100ps
`include "task_array_macros.svh"

module display_sync (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic                                    vga_en,
	input  task_array_pkg::r0_t [`TA_NUM_CORES-1:0] r0_all,
	output logic                                    vga_end,
	output task_array_pkg::r0_t [`TA_NUM_CORES-1:0] r0_snapshot
);

	localparam int SCAN_W = $clog2(`TA_SCAN_CYCLES);

	logic              scanning;
	logic [SCAN_W-1:0] scan_cnt; // Cycles since vga_en
	logic              scan_last;

	assign scan_last = scanning && (scan_cnt == SCAN_W'(`TA_SCAN_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			scanning <= 1'b0;
			scan_cnt <= '0;
			vga_end  <= 1'b0;
		end else begin
			vga_end <= scan_last; // Lands TA_SCAN_CYCLES after vga_en
			if (vga_en && !scanning) begin
				scanning <= 1'b1;
				scan_cnt <= SCAN_W'(1);
			end else if (scan_last) begin
				scanning <= 1'b0;
			end else if (scanning) begin
				scan_cnt <= scan_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (vga_en && !scanning) begin
			r0_snapshot <= r0_all; // Held until the next frame
		end
	end

endmodule

// ==== verilog/task_array_pkg.sv ====
`include "task_array_macros.svh"

package task_array_pkg;

	typedef logic [`TA_NUM_CORES-1:0]              core_mask_t; // One bit per core
	typedef logic [$clog2(`TA_TM_DEPTH)-1:0]       tm_addr_t;
	typedef logic [3:0]                            frame_cnt_t; // Instruction frames left
	typedef logic [$clog2(`TA_INSN_LOAD_TIME)-1:0] load_cnt_t;  // Part index
	typedef logic [`TA_PART_W-1:0]                 part_t;
	typedef logic [`TA_R0_W-1:0]                   r0_t;
	typedef logic [`TA_TM_W-1:0]                   tm_word_t;   // Raw frame

	typedef enum logic [1:0] {
		fence_none = 2'd0,
		fence_acq  = 2'd1, // Later tasks wait for this one
		fence_rel  = 2'd2  // This task waits for all earlier ones
	} fence_e;

	typedef enum logic [1:0] {
		core_idle = 2'd0,
		core_load = 2'd1,
		core_exec = 2'd2
	} core_state_e;

	typedef struct packed {
		frame_cnt_t              frame_cnt; // Zero marks a jump or skip frame
		core_mask_t              core_mask;
		core_mask_t              init_mask;
		fence_e                  fence;
		logic                    stop;
		tm_addr_t                stop_addr;
		r0_t [`TA_NUM_CORES-1:0] init_val;  // Index is core number
		logic [12:0]             pad;
	} ctrl_frame_t;

	// Sits in the low bits of an instruction frame, part 0 is imm
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] exec_cycles;
		logic [7:0] reserved;
		logic [15:0] imm;
	} insn_t;

	typedef struct packed {
		load_cnt_t count;
		part_t     data;
	} core_bus_t;

endpackage

// ==== verilog/task_array_top.sv ====
`timescale 1ns/100ps
`include "task_array_macros.svh"

module task_array_top (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic                                    tm_we,
	input  task_array_pkg::tm_addr_t                tm_addr,
	input  task_array_pkg::tm_word_t                tm_wdata,
	output logic                                    frame_done,
	output task_array_pkg::r0_t [`TA_NUM_CORES-1:0] r0_snapshot
);

	task_array_pkg::tm_word_t                tm_word;
	task_array_pkg::tm_addr_t                task_pointer;
	task_array_pkg::core_mask_t              ready;
	task_array_pkg::core_mask_t              start;
	task_array_pkg::core_bus_t               core_bus;     // Shared by all cores
	task_array_pkg::core_mask_t              init_r0_vect;
	task_array_pkg::r0_t [`TA_NUM_CORES-1:0] init_r0;
	task_array_pkg::r0_t [`TA_NUM_CORES-1:0] r0_all;
	logic                                    vga_en;
	logic                                    vga_end;

	assign frame_done = vga_end;

	task_memory task_memory_i (
		.clk      (clk),
		.tm_we    (tm_we),
		.tm_addr  (tm_addr),
		.tm_wdata (tm_wdata),
		.rd_addr  (task_pointer),
		.rd_word  (tm_word)
	);

	task_scheduler task_scheduler_i (
		.clk          (clk),
		.reset        (reset),
		.tm_word      (tm_word),
		.task_pointer (task_pointer),
		.ready        (ready),
		.start        (start),
		.core_bus     (core_bus),
		.init_r0_vect (init_r0_vect),
		.init_r0      (init_r0),
		.vga_end      (vga_end),
		.vga_en       (vga_en)
	);

	for (genvar i = 0; i < `TA_NUM_CORES; i++) begin : core_gen
		array_core array_core_i (
			.clk        (clk),
			.reset      (reset),
			.start      (start[i]),
			.core_bus   (core_bus),
			.init_r0_en (init_r0_vect[i]),
			.init_r0    (init_r0[i]),
			.ready      (ready[i]),
			.r0         (r0_all[i])
		);
	end

	display_sync display_sync_i (
		.clk         (clk),
		.reset       (reset),
		.vga_en      (vga_en),
		.r0_all      (r0_all),
		.vga_end     (vga_end),
		.r0_snapshot (r0_snapshot)
	);

endmodule

// ==== verilog/task_memory.sv ====
`timescale 1ns/100ps
`include "task_array_macros.svh"

module task_memory (
	input  logic                    clk,
	input  logic                    tm_we,
	input  task_array_pkg::tm_addr_t tm_addr,
	input  task_array_pkg::tm_word_t tm_wdata,
	input  task_array_pkg::tm_addr_t rd_addr,
	output task_array_pkg::tm_word_t rd_word
);

	task_array_pkg::tm_word_t mem [`TA_TM_DEPTH]; // Program of frames

	// Written by the environment while the array is in reset
	always_ff @(posedge clk) begin
		if (tm_we) begin
			mem[tm_addr] <= tm_wdata;
		end
	end

	// Same-cycle read so the scheduler decodes the frame at its pointer
	assign rd_word = mem[rd_addr];

endmodule

// ==== verilog/task_scheduler.sv ====
`timescale 1ns/100ps
`include "task_array_macros.svh"

module task_scheduler (
	input  logic                                          clk,
	input  logic                                          reset,
	input  task_array_pkg::tm_word_t                      tm_word,
	output task_array_pkg::tm_addr_t                      task_pointer,
	input  task_array_pkg::core_mask_t                    ready,
	output task_array_pkg::core_mask_t                    start,
	output task_array_pkg::core_bus_t                     core_bus,
	output task_array_pkg::core_mask_t                    init_r0_vect,
	output task_array_pkg::r0_t [`TA_NUM_CORES-1:0]       init_r0,
	input  logic                                          vga_end,
	output logic                                          vga_en
);

	localparam int DIV_W = $clog2(`TA_BIG_TACT);

	task_array_pkg::ctrl_frame_t ctrl;        // Current word seen as a control frame
	task_array_pkg::core_mask_t  busy;
	task_array_pkg::frame_cnt_t  frame_cnt;   // Instruction frames left in the task
	task_array_pkg::core_mask_t  active_mask;
	task_array_pkg::fence_e      fence;
	task_array_pkg::load_cnt_t   load_cnt;
	task_array_pkg::tm_addr_t    stop_addr_r;
	logic                        stop_r;
	logic                        stop_wait;   // Parked at stop address until frame end
	logic                        vga_end_prev;
	logic [DIV_W-1:0]            div_cnt;

	logic all_ready;
	logic mask_free;
	logic active_ready;
	logic fence_hold;
	logic ctrl_mode;
	logic accept;
	logic jump;
	logic skip;
	logic start_cond;
	logic last_part;
	logic task_end;
	logic div_wrap;

	assign ctrl = task_array_pkg::ctrl_frame_t'(tm_word);
	assign busy = ~ready;

	assign all_ready    = (ready == '1);
	assign mask_free    = ((busy & ctrl.core_mask) == '0); // New group is idle
	assign active_ready = ((busy & active_mask) == '0);

	// Acquire on the running task or release on the new one needs a quiet array
	assign fence_hold = (fence == task_array_pkg::fence_acq) ||
		(ctrl.fence == task_array_pkg::fence_rel);

	assign ctrl_mode = (frame_cnt == '0) && !stop_wait;
	assign accept    = ctrl_mode && (ctrl.frame_cnt != '0) && mask_free &&
		(!fence_hold || all_ready);
	assign jump      = ctrl_mode && (ctrl.frame_cnt == '0) && ctrl.stop && all_ready;
	assign skip      = ctrl_mode && (ctrl.frame_cnt == '0) && !ctrl.stop;

	// Once part 0 is out the rest of the parts follow back to back
	assign start_cond = (frame_cnt != '0) && ((load_cnt != '0) || active_ready);
	assign last_part  = start_cond &&
		(load_cnt == task_array_pkg::load_cnt_t'(`TA_INSN_LOAD_TIME - 1));
	assign task_end   = last_part && (frame_cnt == task_array_pkg::frame_cnt_t'(1));

	assign div_wrap = (div_cnt == DIV_W'(`TA_BIG_TACT - 1));

	assign start         = start_cond ? active_mask : '0;
	assign core_bus.count = load_cnt;
	assign core_bus.data  = tm_word[load_cnt * `TA_PART_W +: `TA_PART_W];

	always_ff @(posedge clk) begin
		if (reset) begin
			task_pointer <= '0;
			frame_cnt    <= '0;
			active_mask  <= '0;
			fence        <= task_array_pkg::fence_none;
			stop_r       <= 1'b0;
			load_cnt     <= '0;
			init_r0_vect <= '0;
		end else begin
			init_r0_vect <= '0; // Init is a single-cycle pulse
			if (jump) begin
				task_pointer <= ctrl.stop_addr;
			end else if (skip) begin
				task_pointer <= task_pointer + 1'b1;
			end else if (accept) begin
				task_pointer <= task_pointer + 1'b1;
				frame_cnt    <= ctrl.frame_cnt;
				active_mask  <= ctrl.core_mask;
				fence        <= ctrl.fence;
				stop_r       <= ctrl.stop;
				init_r0_vect <= ctrl.init_mask & ctrl.core_mask;
			end else if (last_part) begin
				load_cnt  <= '0;
				frame_cnt <= frame_cnt - 1'b1;
				if (task_end && stop_r) begin
					task_pointer <= stop_addr_r;
				end else begin
					task_pointer <= task_pointer + 1'b1;
				end
			end else if (start_cond) begin
				load_cnt <= load_cnt + 1'b1;
			end
		end
	end

	// Task payload taken with the control frame
	always_ff @(posedge clk) begin
		if (accept) begin
			stop_addr_r <= ctrl.stop_addr;
			init_r0     <= ctrl.init_val;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_wrap ? '0 : div_cnt + 1'b1; // Free-running frame divider
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stop_wait    <= 1'b0;
			vga_end_prev <= 1'b0;
			vga_en       <= 1'b0;
		end else begin
			vga_end_prev <= vga_end;
			vga_en       <= stop_wait && div_wrap && all_ready;
			if (task_end && stop_r) begin
				stop_wait <= 1'b1;
			end else if (vga_end && !vga_end_prev) begin
				stop_wait <= 1'b0; // Frame shown, resume the program
			end
		end
	end

endmodule
